// File: rtl/cpuPkg.sv
// word and register types, ALU operations, MIPS opcode and funct codes, stage payloads
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opNor,
        opSlt,
        opSltu,
        opSll,
        opSrl,
        opSra,
        opLui
    } aluOpT;

    // primary opcodes
    localparam logic [5:0] opcRType = 6'h00;
    localparam logic [5:0] opcAddi  = 6'h08;
    localparam logic [5:0] opcAddiu = 6'h09;
    localparam logic [5:0] opcSlti  = 6'h0a;
    localparam logic [5:0] opcSltiu = 6'h0b;
    localparam logic [5:0] opcAndi  = 6'h0c;
    localparam logic [5:0] opcOri   = 6'h0d;
    localparam logic [5:0] opcXori  = 6'h0e;
    localparam logic [5:0] opcLui   = 6'h0f;

    // R-type funct field
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    // decode to execute
    typedef struct packed {
        logic       valid;
        aluOpT      aluOp;
        regAddrT    srcA;
        regAddrT    srcB;
        wordT       valA;
        wordT       valB;
        logic       useImm;
        logic       useShamt;
        wordT       imm;
        logic [4:0] shamt;
        regAddrT    dest;
    } idExT;

    // execute to writeback
    typedef struct packed {
        logic    valid;
        regAddrT dest;
        wordT    result;
    } exWbT;

endpackage

// File: rtl/instrDecoder.sv
// MIPS instruction decoder for the integer ALU subset
`timescale 1ns/1ns

module instrDecoder (
    input  cpuPkg::wordT    instr,
    output cpuPkg::aluOpT   aluOp,
    output cpuPkg::regAddrT rs,
    output cpuPkg::regAddrT rt,
    output cpuPkg::regAddrT dest,
    output cpuPkg::wordT    imm,
    output logic            useImm,
    output logic            useShamt,
    output logic [4:0]      shamt,
    output logic            legal
);
    import cpuPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    regAddrT     rd;
    logic        known;
    logic        signExt;

    // fixed instruction fields
    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        aluOp    = opAdd;
        useImm   = 1'b0;
        useShamt = 1'b0;
        signExt  = 1'b0;
        known    = 1'b1;
        if (opcode == opcRType) begin
            case (funct)
                fnAdd, fnAddu: aluOp = opAdd;
                fnSub, fnSubu: aluOp = opSub;
                fnAnd:         aluOp = opAnd;
                fnOr:          aluOp = opOr;
                fnXor:         aluOp = opXor;
                fnNor:         aluOp = opNor;
                fnSlt:         aluOp = opSlt;
                fnSltu:        aluOp = opSltu;
                fnSll: begin
                    aluOp    = opSll;
                    useShamt = 1'b1;
                end
                fnSrl: begin
                    aluOp    = opSrl;
                    useShamt = 1'b1;
                end
                fnSra: begin
                    aluOp    = opSra;
                    useShamt = 1'b1;
                end
                default:       known = 1'b0;
            endcase
        end else begin
            useImm = 1'b1;
            case (opcode)
                opcAddi, opcAddiu: begin
                    aluOp   = opAdd;
                    signExt = 1'b1;
                end
                opcSlti: begin
                    aluOp   = opSlt;
                    signExt = 1'b1;
                end
                opcSltiu: begin
                    // sign extended, then compared unsigned
                    aluOp   = opSltu;
                    signExt = 1'b1;
                end
                opcAndi: aluOp = opAnd;
                opcOri:  aluOp = opOr;
                opcXori: aluOp = opXor;
                opcLui:  aluOp = opLui;
                default: known = 1'b0;
            endcase
        end
    end

    assign imm = signExt ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

    // rd for R-type, rt for immediates
    assign dest = (opcode == opcRType) ? rd : rt;

    // writes to r0 are dropped here so they never reach writeback
    assign legal = known && (dest != '0);

endmodule

// File: rtl/regFile.sv
// 32-entry register file, two read ports, one write-through write port
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT addrA,
    input  cpuPkg::regAddrT addrB,
    output cpuPkg::wordT    dataA,
    output cpuPkg::wordT    dataB,
    input  logic            wrEn,
    input  cpuPkg::regAddrT wrAddr,
    input  cpuPkg::wordT    wrData
);
    import cpuPkg::*;

    // r0 has no storage
    wordT regs [1:31];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle write is visible to decode
    assign dataA = (addrA == '0) ? '0 :
                   (wrEn && (wrAddr == addrA)) ? wrData :
                   regs[addrA];

    assign dataB = (addrB == '0) ? '0 :
                   (wrEn && (wrAddr == addrB)) ? wrData :
                   regs[addrB];

    // decode already turns r0 destinations into bubbles
    noZeroWrite: assert property (
        @(posedge clk) disable iff (!reset)
        wrEn |-> (wrAddr != '0)
    ) else $error("register file write to r0 at wrData=%h", wrData);

endmodule

// File: rtl/pipeReg.sv
// pipeline stage register with a typed payload
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    reset,
    input  payloadT d,
    output payloadT q
);

    // all zeros on reset so the valid field starts low
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: rtl/operandBypass.sv
// execute operand select with writeback forwarding and immediate routing
`timescale 1ns/1ns

module operandBypass (
    input  cpuPkg::regAddrT srcA,
    input  cpuPkg::regAddrT srcB,
    input  cpuPkg::wordT    valA,
    input  cpuPkg::wordT    valB,
    input  logic            useImm,
    input  logic            useShamt,
    input  cpuPkg::wordT    imm,
    input  logic [4:0]      shamt,
    input  logic            wbValid,
    input  cpuPkg::regAddrT wbAddr,
    input  cpuPkg::wordT    wbData,
    output cpuPkg::wordT    opA,
    output cpuPkg::wordT    opB
);
    import cpuPkg::*;

    logic fwdA;
    logic fwdB;
    wordT regA;
    wordT regB;

    // previous instruction still sits in writeback
    assign fwdA = wbValid && (wbAddr == srcA);
    assign fwdB = wbValid && (wbAddr == srcB);

    assign regA = fwdA ? wbData : valA;
    assign regB = fwdB ? wbData : valB;

    // shifts take rt on B and the shift amount on A
    assign opA = useShamt ? {27'd0, shamt} : regA;
    assign opB = useImm ? imm : regB;

    // relies on decode never issuing a valid r0 destination
    always_comb begin
        noZeroForward: assert final (!(fwdA && (srcA == '0)) && !(fwdB && (srcB == '0)))
            else $error("forwarding selected r0 wbData=%h", wbData);
    end

endmodule

// File: rtl/alu.sv
// 32-bit arithmetic, logic, compare and shift unit
`timescale 1ns/1ns

module alu (
    input  cpuPkg::aluOpT op,
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    output cpuPkg::wordT  result
);
    import cpuPkg::*;

    logic [4:0] shift;

    // shift count comes from the low bits of A
    assign shift = a[4:0];

    always_comb begin
        case (op)
            opAdd: begin
                result = a + b;
            end
            opSub: begin
                result = a - b;
            end
            opAnd: begin
                result = a & b;
            end
            opOr: begin
                result = a | b;
            end
            opXor: begin
                result = a ^ b;
            end
            opNor: begin
                result = ~(a | b);
            end
            opSlt: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            opSltu: begin
                result = (a < b) ? 32'd1 : 32'd0;
            end
            opSll: begin
                result = b << shift;
            end
            opSrl: begin
                result = b >> shift;
            end
            opSra: begin
                // sign bit fills from the left
                result = wordT'($signed(b) >>> shift);
            end
            opLui: begin
                result = b << 16;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rtl/aluPipeline.sv
// three-stage integer pipeline top, decode, execute and writeback
`timescale 1ns/1ns

module aluPipeline (
    input  logic            clk,
    input  logic            reset,
    input  logic            instrValid,
    input  cpuPkg::wordT    instr,
    output logic            wbValid,
    output cpuPkg::regAddrT wbAddr,
    output cpuPkg::wordT    wbData
);
    import cpuPkg::*;

    aluOpT      decOp;
    regAddrT    decRs;
    regAddrT    decRt;
    regAddrT    decDest;
    wordT       decImm;
    logic       decUseImm;
    logic       decUseShamt;
    logic [4:0] decShamt;
    logic       decLegal;
    wordT       rdDataA;
    wordT       rdDataB;
    idExT       idExD;
    idExT       idExQ;
    exWbT       exWbD;
    exWbT       exWbQ;
    wordT       opA;
    wordT       opB;
    wordT       aluResult;

    // decode and register read side by side
    instrDecoder decoder (
        .instr   (instr),
        .aluOp   (decOp),
        .rs      (decRs),
        .rt      (decRt),
        .dest    (decDest),
        .imm     (decImm),
        .useImm  (decUseImm),
        .useShamt(decUseShamt),
        .shamt   (decShamt),
        .legal   (decLegal)
    );

    regFile regs (
        .clk   (clk),
        .reset (reset),
        .addrA (decRs),
        .addrB (decRt),
        .dataA (rdDataA),
        .dataB (rdDataB),
        .wrEn  (exWbQ.valid),
        .wrAddr(exWbQ.dest),
        .wrData(exWbQ.result)
    );

    always_comb begin
        idExD.valid    = instrValid & decLegal;
        idExD.aluOp    = decOp;
        idExD.srcA     = decRs;
        idExD.srcB     = decRt;
        idExD.valA     = rdDataA;
        idExD.valB     = rdDataB;
        idExD.useImm   = decUseImm;
        idExD.useShamt = decUseShamt;
        idExD.imm      = decImm;
        idExD.shamt    = decShamt;
        idExD.dest     = decDest;
    end

    pipeReg #(.payloadT(idExT)) idEx (
        .clk  (clk),
        .reset(reset),
        .d    (idExD),
        .q    (idExQ)
    );

    // execute
    operandBypass bypass (
        .srcA    (idExQ.srcA),
        .srcB    (idExQ.srcB),
        .valA    (idExQ.valA),
        .valB    (idExQ.valB),
        .useImm  (idExQ.useImm),
        .useShamt(idExQ.useShamt),
        .imm     (idExQ.imm),
        .shamt   (idExQ.shamt),
        .wbValid (exWbQ.valid),
        .wbAddr  (exWbQ.dest),
        .wbData  (exWbQ.result),
        .opA     (opA),
        .opB     (opB)
    );

    alu aluUnit (
        .op    (idExQ.aluOp),
        .a     (opA),
        .b     (opB),
        .result(aluResult)
    );

    always_comb begin
        exWbD.valid  = idExQ.valid;
        exWbD.dest   = idExQ.dest;
        exWbD.result = aluResult;
    end

    pipeReg #(.payloadT(exWbT)) exWb (
        .clk  (clk),
        .reset(reset),
        .d    (exWbD),
        .q    (exWbQ)
    );

    // writeback shown on the outputs
    assign wbValid = exWbQ.valid;
    assign wbAddr  = exWbQ.dest;
    assign wbData  = exWbQ.result;

endmodule

// File: bench/tbModel.svh
// reference register model, xorshift generator, instruction encoders, typed compare tasks
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

wordT modelRegs [0:31];

// xorshift32 step
function automatic wordT nextRand(input wordT s);
    wordT x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// registers 1 to 7 only, so dependencies come often
function automatic regAddrT pickReg(input wordT r);
    return regAddrT'((r % 7) + 1);
endfunction

function automatic wordT rTypeWord(input logic [5:0] fn, input regAddrT rd, input regAddrT rs,
                                   input regAddrT rt, input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic wordT iTypeWord(input logic [5:0] opc, input regAddrT rt, input regAddrT rs,
                                   input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

// MIPS integer semantics with no overflow traps
task automatic predictResult(input wordT ins, output logic ok, output regAddrT addr,
                             output wordT val);
    wordT a;
    wordT b;
    wordT se;
    wordT ze;
    a = modelRegs[ins[25:21]];
    b = modelRegs[ins[20:16]];
    se = {{16{ins[15]}}, ins[15:0]};
    ze = {16'h0000, ins[15:0]};
    ok = 1'b1;
    addr = ins[20:16];
    val = '0;
    if (ins[31:26] == 6'h00) begin
        addr = ins[15:11];
        case (ins[5:0])
            6'h20, 6'h21: val = a + b;
            6'h22, 6'h23: val = a - b;
            6'h24: val = a & b;
            6'h25: val = a | b;
            6'h26: val = a ^ b;
            6'h27: val = ~(a | b);
            6'h2a: val = {31'd0, ($signed(a) < $signed(b))};
            6'h2b: val = {31'd0, (a < b)};
            6'h00: val = b << ins[10:6];
            6'h02: val = b >> ins[10:6];
            6'h03: val = wordT'($signed(b) >>> ins[10:6]);
            default: ok = 1'b0;
        endcase
    end else begin
        case (ins[31:26])
            6'h08, 6'h09: val = a + se;
            6'h0a: val = {31'd0, ($signed(a) < $signed(se))};
            6'h0b: val = {31'd0, (a < se)};
            6'h0c: val = a & ze;
            6'h0d: val = a | ze;
            6'h0e: val = a ^ ze;
            6'h0f: val = {ins[15:0], 16'h0000};
            default: ok = 1'b0;
        endcase
    end
    // r0 is never written
    if (addr == '0) begin
        ok = 1'b0;
    end
    if (ok) begin
        modelRegs[addr] = val;
    end
endtask

task automatic checkWord(input string name, input wordT got, input wordT exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        wordErrors++;
    end
endtask

task automatic checkAddr(input string name, input regAddrT got, input regAddrT exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        addrErrors++;
    end
endtask

task automatic checkValid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        validErrors++;
    end
endtask

`endif

// File: bench/aluPipelineTb.sv
// testbench for the integer pipeline with directed table, random phase and watchdog
`timescale 1ns/1ns

module aluPipelineTb;
    import cpuPkg::*;

    typedef struct packed {
        logic    valid;
        regAddrT addr;
        wordT    data;
    } expectT;

    typedef struct packed {
        wordT    instr;
        logic    valid;
        regAddrT addr;
        wordT    data;
    } rowT;

    localparam int randomCount = 300;

    logic       clk;
    logic       reset;
    logic       instrValid;
    wordT       instr;
    logic       wbValid;
    regAddrT    wbAddr;
    wordT       wbData;
    int         wordErrors;
    int         addrErrors;
    int         validErrors;
    int         cycles;
    int         cycleLimit;
    wordT       randState;
    rowT        directed [$];
    expectT     pending [$];
    logic [5:0] rFuncts [13];
    logic [5:0] iOpcodes [8];

    `include "tbModel.svh"

    aluPipeline dut (
        .clk       (clk),
        .reset     (reset),
        .instrValid(instrValid),
        .instr     (instr),
        .wbValid   (wbValid),
        .wbAddr    (wbAddr),
        .wbData    (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog
    initial begin
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cycles < cycleLimit);
        $display("run timed out after %0d cycles before all checks were done", cycles);
        $display("Something failed");
        $finish;
    end

    task automatic addRow(input wordT ins, input logic v, input regAddrT a, input wordT d);
        directed.push_back({ins, v, a, d});
    endtask

    task automatic buildDirected();
        // reset state, then immediates and their extension
        addRow(rTypeWord(6'h20, 5'd1, 5'd0, 5'd0, 5'd0), 1'b1, 5'd1, 32'h00000000);
        addRow(iTypeWord(6'h0d, 5'd2, 5'd0, 16'hffff), 1'b1, 5'd2, 32'h0000ffff);
        addRow(iTypeWord(6'h08, 5'd3, 5'd0, 16'hffff), 1'b1, 5'd3, 32'hffffffff);
        addRow(iTypeWord(6'h0f, 5'd4, 5'd0, 16'h1234), 1'b1, 5'd4, 32'h12340000);
        addRow(iTypeWord(6'h09, 5'd5, 5'd0, 16'h8000), 1'b1, 5'd5, 32'hffff8000);
        addRow(iTypeWord(6'h0c, 5'd6, 5'd3, 16'h00f0), 1'b1, 5'd6, 32'h000000f0);
        addRow(iTypeWord(6'h0e, 5'd7, 5'd2, 16'h0f0f), 1'b1, 5'd7, 32'h0000f0f0);
        addRow(iTypeWord(6'h0a, 5'd1, 5'd3, 16'h0001), 1'b1, 5'd1, 32'h00000001);
        addRow(iTypeWord(6'h0b, 5'd8, 5'd0, 16'hffff), 1'b1, 5'd8, 32'h00000001);
        // register ops
        addRow(rTypeWord(6'h20, 5'd9, 5'd2, 5'd4, 5'd0), 1'b1, 5'd9, 32'h1234ffff);
        addRow(rTypeWord(6'h22, 5'd10, 5'd0, 5'd2, 5'd0), 1'b1, 5'd10, 32'hffff0001);
        addRow(rTypeWord(6'h24, 5'd11, 5'd4, 5'd9, 5'd0), 1'b1, 5'd11, 32'h12340000);
        addRow(rTypeWord(6'h25, 5'd12, 5'd2, 5'd4, 5'd0), 1'b1, 5'd12, 32'h1234ffff);
        addRow(rTypeWord(6'h26, 5'd13, 5'd2, 5'd3, 5'd0), 1'b1, 5'd13, 32'hffff0000);
        addRow(rTypeWord(6'h27, 5'd14, 5'd2, 5'd4, 5'd0), 1'b1, 5'd14, 32'hedcb0000);
        addRow(rTypeWord(6'h2a, 5'd15, 5'd3, 5'd1, 5'd0), 1'b1, 5'd15, 32'h00000001);
        addRow(rTypeWord(6'h2b, 5'd16, 5'd3, 5'd1, 5'd0), 1'b1, 5'd16, 32'h00000000);
        addRow(rTypeWord(6'h03, 5'd17, 5'd0, 5'd5, 5'd4), 1'b1, 5'd17, 32'hfffff800);
        addRow(rTypeWord(6'h02, 5'd18, 5'd0, 5'd5, 5'd4), 1'b1, 5'd18, 32'h0ffff800);
        addRow(rTypeWord(6'h00, 5'd19, 5'd0, 5'd2, 5'd8), 1'b1, 5'd19, 32'h00ffff00);
        // back-to-back and two-apart chains on r20 and r21
        addRow(iTypeWord(6'h09, 5'd20, 5'd0, 16'h0005), 1'b1, 5'd20, 32'h00000005);
        addRow(rTypeWord(6'h20, 5'd20, 5'd20, 5'd20, 5'd0), 1'b1, 5'd20, 32'h0000000a);
        addRow(rTypeWord(6'h00, 5'd21, 5'd0, 5'd20, 5'd2), 1'b1, 5'd21, 32'h00000028);
        addRow(rTypeWord(6'h22, 5'd22, 5'd20, 5'd21, 5'd0), 1'b1, 5'd22, 32'hffffffe2);
        // r0 target, lw opcode and jr funct all become bubbles
        addRow(iTypeWord(6'h08, 5'd0, 5'd0, 16'h0007), 1'b0, 5'd0, 32'h00000000);
        addRow(rTypeWord(6'h21, 5'd23, 5'd0, 5'd4, 5'd0), 1'b1, 5'd23, 32'h12340000);
        addRow(iTypeWord(6'h23, 5'd2, 5'd1, 16'h0004), 1'b0, 5'd0, 32'h00000000);
        addRow(rTypeWord(6'h08, 5'd5, 5'd1, 5'd0, 5'd0), 1'b0, 5'd0, 32'h00000000);
        addRow(rTypeWord(6'h23, 5'd24, 5'd0, 5'd1, 5'd0), 1'b1, 5'd24, 32'hffffffff);
    endtask

    // oldest entry is the one that reaches writeback now
    task automatic popAndCompare();
        expectT e;
        e = pending.pop_front();
        checkValid("wbValid", wbValid, e.valid);
        if (e.valid) begin
            checkAddr("wbAddr", wbAddr, e.addr);
            checkWord("wbData", wbData, e.data);
        end
    endtask

    task automatic issue(input logic v, input wordT ins, input expectT e);
        @(posedge clk);
        instrValid <= v;
        instr <= ins;
        pending.push_back(e);
        @(negedge clk);
        popAndCompare();
    endtask

    initial begin
        rowT     row;
        wordT    ins;
        wordT    fields;
        int      kind;
        logic    ok;
        regAddrT addr;
        wordT    val;
        reset = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        wordErrors = 0;
        addrErrors = 0;
        validErrors = 0;
        randState = 32'd37301;
        rFuncts = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
                    6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
        iOpcodes = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        buildDirected();
        cycleLimit = 10 + directed.size() + randomCount + 20;
        // two empty slots ahead of the first instruction
        pending.push_back('0);
        pending.push_back('0);

        repeat (10) begin
            @(negedge clk);
            checkValid("wbValid", wbValid, 1'b0);
        end
        @(posedge clk);
        reset <= 1'b1;

        foreach (directed[i]) begin
            row = directed[i];
            if (row.valid) begin
                modelRegs[row.addr] = row.data;
            end
            issue(1'b1, row.instr, {row.valid, row.addr, row.data});
        end

        for (int n = 0; n < randomCount; n++) begin
            randState = nextRand(randState);
            kind = int'(randState % 21);
            randState = nextRand(randState);
            fields = randState;
            if (kind < 13) begin
                ins = rTypeWord(rFuncts[4'(kind)], pickReg(fields), pickReg(fields >> 8),
                                pickReg(fields >> 16), fields[28:24]);
            end else begin
                ins = iTypeWord(iOpcodes[3'(kind - 13)], pickReg(fields),
                                pickReg(fields >> 8), fields[31:16]);
            end
            predictResult(ins, ok, addr, val);
            issue(1'b1, ins, {ok, addr, val});
        end

        // drain the last two instructions
        issue(1'b0, '0, '0);
        issue(1'b0, '0, '0);

        $display("errors: valid %0d, address %0d, data %0d", validErrors, addrErrors, wordErrors);
        if (validErrors + addrErrors + wordErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
rtl/cpuPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/pipeReg.sv
rtl/operandBypass.sv
rtl/alu.sv
rtl/aluPipeline.sv
+incdir+bench
bench/aluPipelineTb.sv

// File: run.sh
#!/bin/sh
# build and run the pipeline testbench, fail if the log reports a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module aluPipelineTb -f filelist.f -o simv &&
    ./obj_dir/simv > sim.log 2>&1 ||
    { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0
